//--- design/alu_unit.sv
// Arithmetic, logic, shift, compare and link value unit
`timescale 1ns/10ps

module alu_unit import mini_core_pkg::*; (
    operand_if.unit ops,
    input  word_t   pc,
    output word_t   result
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    // AUIPC takes the PC as operand A
    assign op_a  = ops.decoded.use_pc_as_a ? pc : ops.rs1_data;
    assign op_b  = ops.decoded.use_imm ? ops.decoded.immediate : ops.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ops.decoded.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   result = word_t'(op_a < op_b);
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = word_t'($signed(op_a) >>> shamt);
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            // LUI
            ALU_PASS_B: result = op_b;
            // Return address for JAL and JALR
            ALU_LINK:   result = pc + word_t'(4);
            default:    result = op_a + op_b;
        endcase
    end

endmodule

//--- design/core_control_fsm.sv
// Fetch, wait, decode and execute sequencer with stage strobes
`timescale 1ns/10ps

module core_control_fsm import mini_core_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic imem_valid,
    output logic fetch_req,
    output logic fetch_done,
    output logic decode_en,
    output logic exec_en,
    output logic waiting
);

    core_state_t state;
    core_state_t state_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    // One instruction in flight, memory latency only stretches WAIT
    always_comb begin
        state_next = state;
        case (state)
            FETCH: begin
                state_next = WAIT;
            end
            WAIT: begin
                if (imem_valid) begin
                    state_next = DECODE;
                end
            end
            DECODE: begin
                state_next = EXECUTE;
            end
            EXECUTE: begin
                state_next = FETCH;
            end
            default: begin
                state_next = FETCH;
            end
        endcase
    end

    // Stage strobes, each high for a single cycle
    assign fetch_req  = (state == FETCH);
    assign waiting    = (state == WAIT);
    assign fetch_done = waiting && imem_valid;
    assign decode_en  = (state == DECODE);
    assign exec_en    = (state == EXECUTE);

endmodule

//--- design/instruction_decoder.sv
// Instruction register and RV32I subset decoder
`timescale 1ns/10ps

module instruction_decoder import mini_core_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       fetch_done,
    input  logic       decode_en,
    input  word_t      imem_data,
    operand_if.decoder ops
);

    word_t          instr_q;
    decoded_instr_t decoded_q;
    decoded_instr_t dec_next;
    opcode_t        opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    word_t          imm_i;
    word_t          imm_u;
    word_t          imm_b;
    word_t          imm_j;

    // Shared by OP and OP-IMM, alt selects SUB or SRA
    function automatic alu_op_t funct3_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr_q <= imem_data;
        end
    end

    assign opcode = opcode_t'(instr_q[6:0]);
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];

    //////////////////////////////////////////////////
    // Immediates by format
    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};

    //////////////////////////////////////////////////
    // Field decode
    always_comb begin
        dec_next             = '0;
        dec_next.alu_op      = ALU_ADD;
        dec_next.branch_cond = BR_NONE;
        dec_next.rs1         = instr_q[19:15];
        dec_next.rs2         = instr_q[24:20];
        dec_next.rd          = instr_q[11:7];
        case (opcode)
            OPC_OP: begin
                dec_next.rd_write = 1'b1;
                dec_next.alu_op   = funct3_to_alu(funct3, funct7[5]);
                dec_next.illegal  = (funct7 != 7'b0000000) &&
                                    !(funct7 == 7'b0100000 &&
                                      (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                dec_next.rd_write  = 1'b1;
                dec_next.use_imm   = 1'b1;
                dec_next.immediate = imm_i;
                dec_next.alu_op    = funct3_to_alu(funct3, (funct3 == 3'b101) && funct7[5]);
                if (funct3 == 3'b001) begin
                    dec_next.illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    dec_next.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            OPC_LUI: begin
                dec_next.rd_write  = 1'b1;
                dec_next.use_imm   = 1'b1;
                dec_next.immediate = imm_u;
                dec_next.alu_op    = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                dec_next.rd_write    = 1'b1;
                dec_next.use_imm     = 1'b1;
                dec_next.use_pc_as_a = 1'b1;
                dec_next.immediate   = imm_u;
            end
            OPC_JAL: begin
                dec_next.rd_write    = 1'b1;
                dec_next.immediate   = imm_j;
                dec_next.alu_op      = ALU_LINK;
                dec_next.branch_cond = BR_JAL;
            end
            OPC_JALR: begin
                dec_next.rd_write    = 1'b1;
                dec_next.immediate   = imm_i;
                dec_next.alu_op      = ALU_LINK;
                dec_next.branch_cond = BR_JALR;
                dec_next.illegal     = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                dec_next.immediate = imm_b;
                case (funct3)
                    3'b000:  dec_next.branch_cond = BR_EQ;
                    3'b001:  dec_next.branch_cond = BR_NE;
                    3'b100:  dec_next.branch_cond = BR_LT;
                    3'b101:  dec_next.branch_cond = BR_GE;
                    3'b110:  dec_next.branch_cond = BR_LTU;
                    3'b111:  dec_next.branch_cond = BR_GEU;
                    default: dec_next.illegal = 1'b1;
                endcase
            end
            default: begin
                dec_next.illegal = 1'b1;
            end
        endcase
        // Illegal retires as a no-op falling through to PC+4
        if (dec_next.illegal) begin
            dec_next.rd_write    = 1'b0;
            dec_next.branch_cond = BR_NONE;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decoded_q <= '0;
        end else if (decode_en) begin
            decoded_q <= dec_next;
        end
    end

    assign ops.decoded = decoded_q;
    assign ops.instr   = instr_q;

endmodule

//--- design/mini_core.sv
// Multi-cycle RV32I integer core top level
`timescale 1ns/10ps
`include "mini_core_defines.svh"

module mini_core import mini_core_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    output logic                       imem_req,
    output word_t                      imem_addr,
    input  logic                       imem_valid,
    input  word_t                      imem_data,
    output logic                       tr_retire,
    output logic                       tr_rd_write,
    output logic                       tr_illegal,
    output logic                       tr_branch_taken,
    output word_t                      tr_pc,
    output word_t                      tr_instr,
    output word_t                      tr_rd_data,
    output reg_addr_t                  tr_rd_addr,
    output logic [`MC_COUNT_WIDTH-1:0] tr_instret,
    output logic [`MC_COUNT_WIDTH-1:0] tr_stall_cycles
);

    logic  fetch_req;
    logic  fetch_done;
    logic  decode_en;
    logic  exec_en;
    logic  waiting;
    logic  branch_taken;
    word_t pc;
    word_t alu_result;

    operand_if ops ();

    //////////////////////////////////////////////////
    // Control and counters
    core_control_fsm u_control (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_valid (imem_valid),
        .fetch_req  (fetch_req),
        .fetch_done (fetch_done),
        .decode_en  (decode_en),
        .exec_en    (exec_en),
        .waiting    (waiting)
    );

    perf_counters u_counters (
        .clk          (clk),
        .arst_n       (arst_n),
        .exec_en      (exec_en),
        .waiting      (waiting),
        .imem_valid   (imem_valid),
        .instret      (tr_instret),
        .stall_cycles (tr_stall_cycles)
    );

    //////////////////////////////////////////////////
    // Decode, operands and execution
    instruction_decoder u_decoder (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch_done (fetch_done),
        .decode_en  (decode_en),
        .imem_data  (imem_data),
        .ops        (ops.decoder)
    );

    register_file u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .exec_en (exec_en),
        .wr_data (alu_result),
        .ops     (ops.regfile)
    );

    alu_unit u_alu (
        .ops    (ops.unit),
        .pc     (pc),
        .result (alu_result)
    );

    pc_unit u_pc (
        .clk          (clk),
        .arst_n       (arst_n),
        .exec_en      (exec_en),
        .ops          (ops.unit),
        .pc           (pc),
        .branch_taken (branch_taken)
    );

    // Fetch port
    assign imem_req  = fetch_req;
    assign imem_addr = pc;

    //////////////////////////////////////////////////
    // Trace, meaningful only while tr_retire is high
    assign tr_retire       = exec_en;
    assign tr_pc           = pc;
    assign tr_instr        = ops.instr;
    assign tr_rd_write     = ops.decoded.rd_write && (ops.decoded.rd != '0);
    assign tr_rd_addr      = ops.decoded.rd;
    assign tr_rd_data      = alu_result;
    assign tr_illegal      = ops.decoded.illegal;
    assign tr_branch_taken = branch_taken;

endmodule

//--- design/mini_core_defines.svh
// Core width, register count, reset PC and counter width macros
`ifndef MINI_CORE_DEFINES_SVH
`define MINI_CORE_DEFINES_SVH

// Data and address width
`define MC_XLEN 32

// Architectural integer registers
`define MC_REG_COUNT 32

// First fetch address after reset
`define MC_RESET_PC 32'h0000_0000

// Width of the retire and stall counters
`define MC_COUNT_WIDTH 32

`endif

//--- design/mini_core_pkg.sv
// Word, register address, opcode, ALU, branch, decoded instruction and FSM state types
`include "mini_core_defines.svh"

package mini_core_pkg;

    typedef logic [`MC_XLEN-1:0] word_t;
    typedef logic [$clog2(`MC_REG_COUNT)-1:0] reg_addr_t;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B,
        ALU_LINK
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_JAL,
        BR_JALR
    } branch_cond_t;

    typedef struct packed {
        alu_op_t      alu_op;
        branch_cond_t branch_cond;
        reg_addr_t    rs1;
        reg_addr_t    rs2;
        reg_addr_t    rd;
        logic         rd_write;
        logic         use_imm;
        logic         use_pc_as_a;
        word_t        immediate;
        logic         illegal;
    } decoded_instr_t;

    typedef enum logic [1:0] {
        FETCH,
        WAIT,
        DECODE,
        EXECUTE
    } core_state_t;

endpackage

//--- design/operand_if.sv
// Operand bundle from decode and register file to the execution blocks
`timescale 1ns/10ps

interface operand_if import mini_core_pkg::*; ();

    // Decoder side
    decoded_instr_t decoded;
    word_t          instr;

    // Register file read data
    word_t          rs1_data;
    word_t          rs2_data;

    modport decoder (
        output decoded,
        output instr
    );

    modport regfile (
        input  decoded,
        output rs1_data,
        output rs2_data
    );

    // ALU and PC unit view
    modport unit (
        input decoded,
        input instr,
        input rs1_data,
        input rs2_data
    );

endinterface

//--- design/pc_unit.sv
// Program counter, branch condition evaluation and next PC select
`timescale 1ns/10ps
`include "mini_core_defines.svh"

module pc_unit import mini_core_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    exec_en,
    operand_if.unit ops,
    output word_t   pc,
    output logic    branch_taken
);

    word_t pc_plus4;
    word_t target;
    logic  eq;
    logic  lt;
    logic  ltu;

    assign eq  = (ops.rs1_data == ops.rs2_data);
    assign lt  = ($signed(ops.rs1_data) < $signed(ops.rs2_data));
    assign ltu = (ops.rs1_data < ops.rs2_data);

    always_comb begin
        case (ops.decoded.branch_cond)
            BR_EQ:   branch_taken = eq;
            BR_NE:   branch_taken = !eq;
            BR_LT:   branch_taken = lt;
            BR_GE:   branch_taken = !lt;
            BR_LTU:  branch_taken = ltu;
            BR_GEU:  branch_taken = !ltu;
            BR_JAL:  branch_taken = 1'b1;
            BR_JALR: branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    // JALR is register relative with bit 0 dropped
    assign pc_plus4 = pc + word_t'(4);
    assign target   = (ops.decoded.branch_cond == BR_JALR) ?
                      ((ops.rs1_data + ops.decoded.immediate) & ~word_t'(1)) :
                      (pc + ops.decoded.immediate);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `MC_RESET_PC;
        end else if (exec_en) begin
            pc <= branch_taken ? target : pc_plus4;
        end
    end

endmodule

//--- design/perf_counters.sv
// Retired instruction and fetch stall cycle counters
`timescale 1ns/10ps
`include "mini_core_defines.svh"

module perf_counters (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       exec_en,
    input  logic                       waiting,
    input  logic                       imem_valid,
    output logic [`MC_COUNT_WIDTH-1:0] instret,
    output logic [`MC_COUNT_WIDTH-1:0] stall_cycles
);

    logic stall;

    // The cycle that brings imem_valid is not a stall
    assign stall = waiting && !imem_valid;

    // Both counters wrap at full width
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instret <= '0;
        end else if (exec_en) begin
            instret <= instret + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stall_cycles <= '0;
        end else if (stall) begin
            stall_cycles <= stall_cycles + 1'b1;
        end
    end

endmodule

//--- design/register_file.sv
// 32 x 32 integer register file with two read ports and one write port
`timescale 1ns/10ps
`include "mini_core_defines.svh"

module register_file import mini_core_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       exec_en,
    input  word_t      wr_data,
    operand_if.regfile ops
);

    word_t regs [`MC_REG_COUNT];
    logic  wr_en;

    // x0 is never written
    assign wr_en = exec_en && ops.decoded.rd_write && (ops.decoded.rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MC_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[ops.decoded.rd] <= wr_data;
        end
    end

    // Combinational reads, x0 forced to zero
    assign ops.rs1_data = (ops.decoded.rs1 == '0) ? '0 : regs[ops.decoded.rs1];
    assign ops.rs2_data = (ops.decoded.rs2 == '0) ? '0 : regs[ops.decoded.rs2];

endmodule

//--- mini_core.f
+incdir+design
design/mini_core_pkg.sv
design/operand_if.sv
design/core_control_fsm.sv
design/perf_counters.sv
design/instruction_decoder.sv
design/register_file.sv
design/alu_unit.sv
design/pc_unit.sv
design/mini_core.sv
testbench/mini_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module mini_core_tb \
    -f mini_core.f -o mini_core_sim

sim_out=$(./obj_dir/mini_core_sim 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "Testbench passed"; then
    exit 0
else
    exit 1
fi

//--- testbench/mini_core_tb.sv
// Testbench for mini_core with random instruction memory, reference model and compare tasks
`timescale 1ns/10ps
`include "mini_core_defines.svh"

module mini_core_tb import mini_core_pkg::*; ();

    localparam int NUM_RETIRE = 600;
    localparam int TIMEOUT    = 50;

    logic                       clk;
    logic                       arst_n;
    logic                       imem_req;
    word_t                      imem_addr;
    logic                       imem_valid;
    word_t                      imem_data;
    logic                       tr_retire;
    logic                       tr_rd_write;
    logic                       tr_illegal;
    logic                       tr_branch_taken;
    word_t                      tr_pc;
    word_t                      tr_instr;
    word_t                      tr_rd_data;
    reg_addr_t                  tr_rd_addr;
    logic [`MC_COUNT_WIDTH-1:0] tr_instret;
    logic [`MC_COUNT_WIDTH-1:0] tr_stall_cycles;

    integer                     seed = 29799;
    word_t                      mem [256];
    word_t                      model_regs [32];
    word_t                      model_pc;
    int                         retired;
    logic [`MC_COUNT_WIDTH-1:0] stall_sum;

    mini_core u_mini_core (
        .clk             (clk),
        .arst_n          (arst_n),
        .imem_req        (imem_req),
        .imem_addr       (imem_addr),
        .imem_valid      (imem_valid),
        .imem_data       (imem_data),
        .tr_retire       (tr_retire),
        .tr_rd_write     (tr_rd_write),
        .tr_illegal      (tr_illegal),
        .tr_branch_taken (tr_branch_taken),
        .tr_pc           (tr_pc),
        .tr_instr        (tr_instr),
        .tr_rd_data      (tr_rd_data),
        .tr_rd_addr      (tr_rd_addr),
        .tr_instret      (tr_instret),
        .tr_stall_cycles (tr_stall_cycles)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Failure reporting and compare tasks
    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: no %s within %0d cycles at %0t ns", what, TIMEOUT, $time);
        abort_run();
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input logic [`MC_COUNT_WIDTH-1:0] got,
                               input logic [`MC_COUNT_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Program image with roughly 90% legal subset encodings
    task automatic fill_memory();
        word_t      r;
        word_t      w;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        int         kind;
        for (int i = 0; i < 256; i++) begin
            r    = $random(seed);
            rd   = r[4:0];
            rs1  = r[9:5];
            rs2  = r[14:10];
            f3   = r[17:15];
            r    = $random(seed);
            imm  = r[11:0];
            kind = $unsigned($random(seed)) % 20;
            case (kind)
                0, 1: w = $random(seed);
                2, 3, 4, 5: begin
                    f7 = (r[20] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
                    w  = {f7, rs2, rs1, f3, rd, 7'h33};
                end
                6, 7, 8, 9: begin
                    if (f3 == 3'd1) begin
                        imm[11:5] = 7'h00;
                    end else if (f3 == 3'd5) begin
                        imm[11:5] = r[20] ? 7'h20 : 7'h00;
                    end
                    w = {imm, rs1, f3, rd, 7'h13};
                end
                10, 11: w = {r[31:12], rd, 7'h37};
                12, 13: w = {r[31:12], rd, 7'h17};
                14:     w = {r[31:12], rd, 7'h6f};
                15:     w = {imm, rs1, 3'b000, rd, 7'h67};
                default: begin
                    // funct3 010 and 011 are not branches
                    if (f3[2:1] == 2'b01) begin
                        f3[2] = 1'b1;
                    end
                    w = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h63};
                end
            endcase
            mem[i] = w;
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model of the RV32I subset
    function automatic word_t arith_ref(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        word_t res;
        case (f3)
            3'd0:    res = alt ? a - b : a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = word_t'($signed(a) < $signed(b));
            3'd3:    res = word_t'(a < b);
            3'd4:    res = a ^ b;
            3'd5:    res = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    task automatic model_step(input word_t ins, output logic wr, output word_t data,
                              output logic ill, output logic taken, output word_t nxt);
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_b;
        word_t      imm_j;
        logic [2:0] f3;
        logic [6:0] f7;
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        f3    = ins[14:12];
        f7    = ins[31:25];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        wr    = 1'b0;
        data  = '0;
        ill   = 1'b0;
        taken = 1'b0;
        nxt   = model_pc + 32'd4;
        case (ins[6:0])
            7'h33: begin
                ill  = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                wr   = !ill;
                data = arith_ref(f3, ins[30], a, b);
            end
            7'h13: begin
                ill  = (f3 == 3'd1 && f7 != 7'h00) ||
                       (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
                wr   = !ill;
                data = arith_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
            end
            7'h37: begin
                wr   = 1'b1;
                data = {ins[31:12], 12'b0};
            end
            7'h17: begin
                wr   = 1'b1;
                data = model_pc + {ins[31:12], 12'b0};
            end
            7'h6f: begin
                wr    = 1'b1;
                data  = model_pc + 32'd4;
                taken = 1'b1;
                nxt   = model_pc + imm_j;
            end
            7'h67: begin
                ill = (f3 != 3'd0);
                if (!ill) begin
                    wr    = 1'b1;
                    data  = model_pc + 32'd4;
                    taken = 1'b1;
                    nxt   = (a + imm_i) & 32'hffff_fffe;
                end
            end
            7'h63: begin
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    3'd7:    taken = (a >= b);
                    default: ill = 1'b1;
                endcase
                if (taken) begin
                    nxt = model_pc + imm_b;
                end
            end
            default: ill = 1'b1;
        endcase
    endtask

    //////////////////////////////////////////////////
    // One fetch, response and retirement
    task automatic run_one_instruction();
        int    waited;
        int    lat;
        logic  retire_seen;
        word_t ins;
        logic  wr;
        word_t data;
        logic  ill;
        logic  taken;
        word_t nxt;
        waited = 0;
        while (!imem_req) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("imem_req");
            end
        end
        if (retired == 0 && waited != 0) begin
            $display("first imem_req came %0d cycles late after reset at %0t ns", waited, $time);
            abort_run();
        end
        if (retired > 0 && waited != 1) begin
            $display("imem_req came %0d cycles after tr_retire at %0t ns", waited, $time);
            abort_run();
        end
        check_word("imem_addr", imem_addr, model_pc);
        ins = mem[imem_addr[9:2]];
        lat = 1 + ($unsigned($random(seed)) % 4);
        stall_sum = stall_sum + (`MC_COUNT_WIDTH)'(lat - 1);
        for (int i = 1; i <= lat; i++) begin
            @(posedge clk);
            #1;
            check_flag("imem_req", imem_req, 1'b0);
            check_flag("tr_retire", tr_retire, 1'b0);
            #1;
            if (i == lat) begin
                imem_valid = 1'b1;
                imem_data  = ins;
            end
        end
        // Count cycles from the accepted response to tr_retire
        waited      = 0;
        retire_seen = 1'b0;
        while (!retire_seen) begin
            @(posedge clk);
            #1;
            waited++;
            retire_seen = tr_retire;
            if (!retire_seen) begin
                check_flag("imem_req", imem_req, 1'b0);
            end
            if (waited > TIMEOUT) begin
                report_timeout("tr_retire");
            end
            if (waited == 1) begin
                #1;
                imem_valid = 1'b0;
                imem_data  = $random(seed);
            end
        end
        if (waited != 2) begin
            $display("tr_retire came %0d cycles after imem_valid at %0t ns", waited, $time);
            abort_run();
        end
        model_step(ins, wr, data, ill, taken, nxt);
        check_word("tr_pc", tr_pc, model_pc);
        check_word("tr_instr", tr_instr, ins);
        check_flag("tr_illegal", tr_illegal, ill);
        check_flag("tr_branch_taken", tr_branch_taken, taken);
        check_flag("tr_rd_write", tr_rd_write, wr && (ins[11:7] != 5'd0));
        check_count("tr_instret", tr_instret, (`MC_COUNT_WIDTH)'(retired));
        if (wr && ins[11:7] != 5'd0) begin
            check_reg_addr("tr_rd_addr", tr_rd_addr, reg_addr_t'(ins[11:7]));
            check_word("tr_rd_data", tr_rd_data, data);
            model_regs[ins[11:7]] = data;
        end
        model_pc = nxt;
        retired++;
    endtask

    initial begin
        arst_n     = 1'b0;
        imem_valid = 1'b0;
        imem_data  = '0;
        retired    = 0;
        stall_sum  = '0;
        model_pc   = `MC_RESET_PC;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        fill_memory();
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check_count("tr_instret", tr_instret, '0);
        check_count("tr_stall_cycles", tr_stall_cycles, '0);
        check_flag("tr_retire", tr_retire, 1'b0);
        while (retired < NUM_RETIRE) begin
            run_one_instruction();
        end
        // Counters settle one edge after the last retirement
        @(posedge clk);
        #1;
        check_count("tr_instret", tr_instret, (`MC_COUNT_WIDTH)'(retired));
        check_count("tr_stall_cycles", tr_stall_cycles, stall_sum);
        $display("Testbench passed");
        $finish;
    end

endmodule
